/* project.f */
+incdir+testbench
design/calc_pkg.sv
design/int_regfile.sv
design/calc_issue.sv
design/pipe_int.sv
design/pipe_mul.sv
design/calc_pipeline.sv
design/calculator_top.sv
testbench/tb_calculator.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the calculator testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_calculator -o tb_calculator \
  && ./obj_dir/tb_calculator | tee /dev/stderr | grep -q "^All tests passed$" \
  && { echo "Simulation PASSED"; exit 0; } \
  || { echo "Simulation FAILED"; exit 1; }

/* testbench/tb_tests.svh */
// --------------------
// Directed tests for the calculator back end
// --------------------

task automatic run_alu_ops();
  issue(calc_pkg::op_lui, 5'd1, 5'd0, 5'd0, 32'h8765_4321);
  issue(calc_pkg::op_addi, 5'd2, 5'd0, 5'd0, 32'd5);
  issue(calc_pkg::op_lui, 5'd3, 5'd0, 5'd0, 32'hFFFF_FF00);
  for (int i = 0; i <= int'(calc_pkg::op_sltu); i++)
  begin
    issue(calc_pkg::calc_op_e'(4'(i)), 5'(8 + i), 5'd1, 5'd2, 32'd0);
  end
  // Negative rs1 for the signed compare and arithmetic shift
  issue(calc_pkg::op_sra, 5'd18, 5'd3, 5'd2, 32'd0);
  issue(calc_pkg::op_slt, 5'd19, 5'd3, 5'd2, 32'd0);
  issue(calc_pkg::op_sltu, 5'd20, 5'd3, 5'd2, 32'd0);
  issue(calc_pkg::op_addi, 5'd21, 5'd1, 5'd0, 32'hFFFF_FFFF);
  idle(4);
endtask

task automatic run_dep_chains();
  // Distance 5 reads the stored register value
  for (int d = 1; d <= 5; d++)
  begin
    issue(calc_pkg::op_addi, 5'd5, 5'd0, 5'd0, 32'(100 * d));
    repeat (d - 1)
    begin
      issue(calc_pkg::op_addi, 5'd30, 5'd30, 5'd0, 32'd1);
    end
    issue(calc_pkg::op_add, 5'd6, 5'd5, 5'd5, 32'd0);
  end
  repeat (6)
  begin
    issue(calc_pkg::op_addi, 5'd7, 5'd7, 5'd0, 32'd3);
  end
  issue(calc_pkg::op_sub, 5'd8, 5'd0, 5'd7, 32'd0);
  idle(4);
endtask

task automatic run_mul_ops();
  issue(calc_pkg::op_lui, 5'd11, 5'd0, 5'd0, 32'hDEAD_BEEF);
  issue(calc_pkg::op_lui, 5'd12, 5'd0, 5'd0, 32'h1234_5678);
  issue(calc_pkg::op_mul, 5'd13, 5'd11, 5'd12, 32'd0);
  issue(calc_pkg::op_mulhu, 5'd14, 5'd11, 5'd12, 32'd0);
  idle(1);
  issue(calc_pkg::op_add, 5'd15, 5'd13, 5'd14, 32'd0);
  issue(calc_pkg::op_mulhu, 5'd16, 5'd15, 5'd11, 32'd0);
  issue(calc_pkg::op_addi, 5'd17, 5'd13, 5'd0, 32'd9);
  issue(calc_pkg::op_xor, 5'd18, 5'd16, 5'd17, 32'd0);
  issue(calc_pkg::op_mul, 5'd19, 5'd12, 5'd12, 32'd0);
  issue(calc_pkg::op_addi, 5'd20, 5'd0, 5'd0, 32'd7);
  issue(calc_pkg::op_or, 5'd21, 5'd19, 5'd20, 32'd0);
  idle(4);
endtask

task automatic run_flush();
  issue(calc_pkg::op_lui, 5'd21, 5'd0, 5'd0, 32'hAAAA_0001);
  issue(calc_pkg::op_lui, 5'd22, 5'd0, 5'd0, 32'hBBBB_0002);
  // Three slots older than the flush, still completes
  issue(calc_pkg::op_addi, 5'd23, 5'd0, 5'd0, 32'd77);
  issue_ex(calc_pkg::op_lui, 5'd21, 5'd0, 5'd0, 32'h1111_1111, 1'b0, 1'b1);
  issue_ex(calc_pkg::op_mul, 5'd22, 5'd21, 5'd21, 32'd0, 1'b0, 1'b1);
  issue_ex(calc_pkg::op_lui, 5'd24, 5'd0, 5'd0, 32'h2222_2222, 1'b1, 1'b1);
  issue(calc_pkg::op_add, 5'd25, 5'd21, 5'd22, 32'd0);
  issue(calc_pkg::op_addi, 5'd26, 5'd24, 5'd0, 32'd1);
  issue(calc_pkg::op_add, 5'd27, 5'd23, 5'd0, 32'd0);
  idle(4);
endtask

task automatic run_zero_reg();
  issue(calc_pkg::op_addi, 5'd0, 5'd1, 5'd0, 32'd5);
  issue(calc_pkg::op_nop, 5'd9, 5'd1, 5'd2, 32'hFFFF_FFFF);
  issue(calc_pkg::op_add, 5'd28, 5'd0, 5'd0, 32'd0);
  issue(calc_pkg::op_mul, 5'd0, 5'd1, 5'd2, 32'd0);
  issue(calc_pkg::op_or, 5'd29, 5'd0, 5'd9, 32'd0);
  idle(4);
endtask

task automatic run_random_mix();
  logic [31:0]         rnd;
  calc_pkg::calc_op_e  op;
  calc_pkg::reg_addr_t rd;
  calc_pkg::reg_addr_t rs1;
  calc_pkg::reg_addr_t rs2;
  calc_pkg::word_t     imm;
  for (int n = 0; n < random_count; n++)
  begin
    rnd = $random(seed);
    imm = $random(seed);
    op  = calc_pkg::calc_op_e'(4'(rnd % 32'd15));
    // Eight registers keep dependencies frequent
    rd  = {2'b00, rnd[6:4]};
    rs1 = {2'b00, rnd[9:7]};
    rs2 = {2'b00, rnd[12:10]};
    if (rnd[15:13] == 3'd0)
    begin
      idle(1);
    end
    // Product not ready for a reader one slot behind
    if ((last_mul_rd != '0) && ((rs1 == last_mul_rd) || (rs2 == last_mul_rd)))
    begin
      idle(1);
    end
    issue(op, rd, rs1, rs2, imm);
  end
  idle(4);
endtask

/* testbench/tb_calculator.sv */
// --------------------
// tb_calculator
// Testbench for the calculator back end with a reference register
// model, a commit and writeback monitor and the test sequence
// --------------------
`timescale 1ns/1ps

module tb_calculator;

  localparam int clk_period      = 10;
  localparam int reset_cycles    = 10;
  localparam int directed_cycles = 150;
  localparam int random_count    = 200;
  // Up to two bubbles per random instruction
  localparam int random_cycles   = 3 * random_count;
  localparam int margin_cycles   = 100;
  localparam int timeout_cycles  = reset_cycles + directed_cycles + random_cycles
                                 + margin_cycles;

  logic                clk_i;
  logic                rst_i;
  logic                dispatch_v_i;
  logic                flush_i;
  calc_pkg::calc_op_e  dispatch_op_i;
  calc_pkg::word_t     dispatch_pc_i;
  calc_pkg::word_t     dispatch_imm_i;
  calc_pkg::reg_addr_t dispatch_rd_i;
  calc_pkg::reg_addr_t dispatch_rs1_i;
  calc_pkg::reg_addr_t dispatch_rs2_i;
  logic                commit_v_o;
  logic                wb_v_o;
  calc_pkg::word_t     commit_pc_o;
  calc_pkg::word_t     wb_data_o;
  calc_pkg::reg_addr_t wb_rd_o;

  int                  seed;
  int                  errors = 0;
  int                  checks = 0;
  int                  edges = 0;
  calc_pkg::word_t     next_pc;
  calc_pkg::reg_addr_t last_mul_rd;
  calc_pkg::word_t     ref_regs [calc_pkg::num_regs];

  // Expected commits and writebacks, oldest first
  calc_pkg::word_t     exp_pc_q [$];
  int                  exp_commit_edge_q [$];
  calc_pkg::reg_addr_t exp_rd_q [$];
  calc_pkg::word_t     exp_data_q [$];
  int                  exp_wb_edge_q [$];

  calculator_top u_dut
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.flush_i(flush_i)
     ,.dispatch_op_i(dispatch_op_i)
     ,.dispatch_pc_i(dispatch_pc_i)
     ,.dispatch_imm_i(dispatch_imm_i)
     ,.dispatch_rd_i(dispatch_rd_i)
     ,.dispatch_rs1_i(dispatch_rs1_i)
     ,.dispatch_rs2_i(dispatch_rs2_i)
     ,.commit_v_o(commit_v_o)
     ,.wb_v_o(wb_v_o)
     ,.commit_pc_o(commit_pc_o)
     ,.wb_data_o(wb_data_o)
     ,.wb_rd_o(wb_rd_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(clk_period / 2) clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    edges <= edges + 1;
  end

  task automatic compare_values
    (input string         name
     , input logic [31:0] got
     , input logic [31:0] exp
     );
    checks = checks + 1;
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  // Result rules per opcode, unsigned product for both multiplies
  function automatic calc_pkg::word_t model_result
    (input calc_pkg::calc_op_e op
     , input calc_pkg::word_t  a
     , input calc_pkg::word_t  b
     , input calc_pkg::word_t  imm
     );
    logic [63:0] prod;
    logic [63:0] sign_ext;
    logic        less;
    prod     = {32'd0, a} * {32'd0, b};
    // Sign fill shifts down from the upper half
    sign_ext = {{32{a[31]}}, a} >> b[4:0];
    // Opposite signs decided by the sign bit alone
    less     = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
      calc_pkg::op_add:   model_result = a + b;
      calc_pkg::op_sub:   model_result = a - b;
      calc_pkg::op_and:   model_result = a & b;
      calc_pkg::op_or:    model_result = a | b;
      calc_pkg::op_xor:   model_result = a ^ b;
      calc_pkg::op_sll:   model_result = a << b[4:0];
      calc_pkg::op_srl:   model_result = a >> b[4:0];
      calc_pkg::op_sra:   model_result = sign_ext[31:0];
      calc_pkg::op_slt:   model_result = {31'd0, less};
      calc_pkg::op_sltu:  model_result = {31'd0, (a < b)};
      calc_pkg::op_addi:  model_result = a + imm;
      calc_pkg::op_lui:   model_result = imm;
      calc_pkg::op_mul:   model_result = prod[31:0];
      calc_pkg::op_mulhu: model_result = prod[63:32];
      default:            model_result = '0;
    endcase
  endfunction

  task automatic issue_ex
    (input calc_pkg::calc_op_e  op
     , input calc_pkg::reg_addr_t rd
     , input calc_pkg::reg_addr_t rs1
     , input calc_pkg::reg_addr_t rs2
     , input calc_pkg::word_t     imm
     , input logic                flush
     , input logic                killed
     );
    calc_pkg::word_t res;
    int              disp_edge;
    @(posedge clk_i);
    // This edge is not counted yet, the DUT samples on the next one
    disp_edge = edges + 2;
    dispatch_v_i   <= 1'b1;
    flush_i        <= flush;
    dispatch_op_i  <= op;
    dispatch_pc_i  <= next_pc;
    dispatch_imm_i <= imm;
    dispatch_rd_i  <= rd;
    dispatch_rs1_i <= rs1;
    dispatch_rs2_i <= rs2;
    if (!killed)
    begin
      res = model_result(op, ref_regs[rs1], ref_regs[rs2], imm);
      exp_pc_q.push_back(next_pc);
      exp_commit_edge_q.push_back(disp_edge + calc_pkg::commit_stage);
      // Nop and register zero commit without a write
      if ((op != calc_pkg::op_nop) && (rd != '0))
      begin
        ref_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_wb_edge_q.push_back(disp_edge + calc_pkg::wb_stage);
      end
    end
    last_mul_rd = ((op == calc_pkg::op_mul) || (op == calc_pkg::op_mulhu)) ? rd : '0;
    next_pc     = next_pc + 32'd4;
  endtask

  task automatic issue
    (input calc_pkg::calc_op_e  op
     , input calc_pkg::reg_addr_t rd
     , input calc_pkg::reg_addr_t rs1
     , input calc_pkg::reg_addr_t rs2
     , input calc_pkg::word_t     imm
     );
    issue_ex(op, rd, rs1, rs2, imm, 1'b0, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      dispatch_v_i <= 1'b0;
      flush_i      <= 1'b0;
    end
    if (n > 0)
    begin
      last_mul_rd = '0;
    end
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    idle(1);
    while (((exp_pc_q.size() != 0) || (exp_rd_q.size() != 0))
           && (waited < 2 * calc_pkg::stage_els))
    begin
      @(posedge clk_i);
      waited = waited + 1;
    end
    if ((exp_pc_q.size() != 0) || (exp_rd_q.size() != 0))
    begin
      $display("ERROR: %0d commits and %0d writebacks never came out of the DUT",
               exp_pc_q.size(), exp_rd_q.size());
      errors = errors + 1;
    end
  endtask

  `include "tb_tests.svh"

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk_i)
  begin
    if (!rst_i && commit_v_o)
    begin
      if (exp_pc_q.size() == 0)
      begin
        $display("ERROR: commit of pc %h while no instruction was pending", commit_pc_o);
        errors = errors + 1;
      end
      else
      begin
        compare_values("commit_pc_o", commit_pc_o, exp_pc_q.pop_front());
        compare_values("commit_v_o edge", edges, exp_commit_edge_q.pop_front());
      end
    end
    if (!rst_i && wb_v_o)
    begin
      if (exp_rd_q.size() == 0)
      begin
        $display("ERROR: writeback to r%0d while no write was pending", wb_rd_o);
        errors = errors + 1;
      end
      else
      begin
        compare_values("wb_rd_o", 32'(wb_rd_o), 32'(exp_rd_q.pop_front()));
        compare_values("wb_data_o", wb_data_o, exp_data_q.pop_front());
        compare_values("wb_v_o edge", edges, exp_wb_edge_q.pop_front());
      end
    end
  end

  initial
  begin
    #(timeout_cycles * clk_period);
    $display("ERROR: timeout after %0d cycles, the test sequence did not finish",
             timeout_cycles);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    seed        = 89;
    next_pc     = 32'h0000_1000;
    last_mul_rd = '0;
    for (int i = 0; i < calc_pkg::num_regs; i++)
    begin
      ref_regs[i] = '0;
    end
    rst_i          <= 1'b1;
    dispatch_v_i   <= 1'b0;
    flush_i        <= 1'b0;
    dispatch_op_i  <= calc_pkg::op_nop;
    dispatch_pc_i  <= '0;
    dispatch_imm_i <= '0;
    dispatch_rd_i  <= '0;
    dispatch_rs1_i <= '0;
    dispatch_rs2_i <= '0;
    repeat (reset_cycles) @(posedge clk_i);
    rst_i <= 1'b0;

    run_alu_ops();
    run_dep_chains();
    run_mul_ops();
    run_flush();
    run_zero_reg();
    run_random_mix();
    drain_pipeline();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* design/calculator_top.sv */
// --------------------
// calculator_top
// Integer calculator back end, register file, issue, ALU and
// multiplier pipes and the completion pipeline
// --------------------
`timescale 1ns/1ps

module calculator_top
  (input  logic                clk_i
   , input  logic                rst_i
   , input  logic                dispatch_v_i
   , input  logic                flush_i
   , input  calc_pkg::calc_op_e  dispatch_op_i
   , input  calc_pkg::word_t     dispatch_pc_i
   , input  calc_pkg::word_t     dispatch_imm_i
   , input  calc_pkg::reg_addr_t dispatch_rd_i
   , input  calc_pkg::reg_addr_t dispatch_rs1_i
   , input  calc_pkg::reg_addr_t dispatch_rs2_i
   , output logic                commit_v_o
   , output logic                wb_v_o
   , output calc_pkg::word_t     commit_pc_o
   , output calc_pkg::word_t     wb_data_o
   , output calc_pkg::reg_addr_t wb_rd_o
   );

  calc_pkg::word_t      rf_rs1;
  calc_pkg::word_t      rf_rs2;
  calc_pkg::calc_op_e   ex1_op;
  calc_pkg::word_t      ex1_rs1;
  calc_pkg::word_t      ex1_rs2;
  calc_pkg::word_t      ex1_imm;
  calc_pkg::stage_ctl_t isd_ctl;
  calc_pkg::word_t      int_data;
  calc_pkg::word_t      mul_data;

  logic [calc_pkg::stage_els-1:1]                fwd_v;
  calc_pkg::reg_addr_t [calc_pkg::stage_els-1:1] fwd_rd;
  calc_pkg::word_t [calc_pkg::stage_els-1:1]     fwd_data;

  // Writeback also drives the register file write port
  int_regfile u_regfile
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.rs1_addr_i(dispatch_rs1_i)
     ,.rs2_addr_i(dispatch_rs2_i)
     ,.rs1_data_o(rf_rs1)
     ,.rs2_data_o(rf_rs2)
     ,.w_v_i(wb_v_o)
     ,.w_addr_i(wb_rd_o)
     ,.w_data_i(wb_data_o)
     );

  calc_issue u_issue
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.flush_i(flush_i)
     ,.dispatch_op_i(dispatch_op_i)
     ,.dispatch_pc_i(dispatch_pc_i)
     ,.dispatch_imm_i(dispatch_imm_i)
     ,.dispatch_rd_i(dispatch_rd_i)
     ,.dispatch_rs1_i(dispatch_rs1_i)
     ,.dispatch_rs2_i(dispatch_rs2_i)
     ,.rf_rs1_i(rf_rs1)
     ,.rf_rs2_i(rf_rs2)
     ,.fwd_v_i(fwd_v)
     ,.fwd_rd_i(fwd_rd)
     ,.fwd_data_i(fwd_data)
     ,.ex1_op_o(ex1_op)
     ,.ex1_rs1_o(ex1_rs1)
     ,.ex1_rs2_o(ex1_rs2)
     ,.ex1_imm_o(ex1_imm)
     ,.isd_ctl_o(isd_ctl)
     );

  pipe_int u_pipe_int
    (.op_i(ex1_op)
     ,.rs1_i(ex1_rs1)
     ,.rs2_i(ex1_rs2)
     ,.imm_i(ex1_imm)
     ,.data_o(int_data)
     );

  pipe_mul u_pipe_mul
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.op_i(ex1_op)
     ,.rs1_i(ex1_rs1)
     ,.rs2_i(ex1_rs2)
     ,.data_o(mul_data)
     );

  calc_pipeline u_pipeline
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.flush_i(flush_i)
     ,.isd_ctl_i(isd_ctl)
     ,.int_data_i(int_data)
     ,.mul_data_i(mul_data)
     ,.fwd_v_o(fwd_v)
     ,.fwd_rd_o(fwd_rd)
     ,.fwd_data_o(fwd_data)
     ,.commit_v_o(commit_v_o)
     ,.commit_pc_o(commit_pc_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_o(wb_rd_o)
     ,.wb_data_o(wb_data_o)
     );

endmodule

/* design/calc_pipeline.sv */
// --------------------
// calc_pipeline
// Stage control shift register with poison, completion result chain,
// forwarding taps and the commit and writeback outputs
// --------------------
`timescale 1ns/1ps

module calc_pipeline
  (input  logic                                          clk_i
   , input  logic                                          rst_i
   , input  logic                                          flush_i
   , input  calc_pkg::stage_ctl_t                          isd_ctl_i
   , input  calc_pkg::word_t                               int_data_i
   , input  calc_pkg::word_t                               mul_data_i
   , output logic [calc_pkg::stage_els-1:1]                fwd_v_o
   , output calc_pkg::reg_addr_t [calc_pkg::stage_els-1:1] fwd_rd_o
   , output calc_pkg::word_t [calc_pkg::stage_els-1:1]     fwd_data_o
   , output logic                                          commit_v_o
   , output calc_pkg::word_t                               commit_pc_o
   , output logic                                          wb_v_o
   , output calc_pkg::reg_addr_t                           wb_rd_o
   , output calc_pkg::word_t                               wb_data_o
   );

  calc_pkg::stage_ctl_t [calc_pkg::stage_els-1:0] stage_r;
  calc_pkg::stage_ctl_t [calc_pkg::stage_els-1:0] stage_n;
  calc_pkg::word_t      [calc_pkg::stage_els-1:0] comp_r;
  calc_pkg::word_t      [calc_pkg::stage_els-1:0] comp_n;

  // Shift control down, flush kills everything not yet committed
  always_comb
  begin
    stage_n[0] = isd_ctl_i;
    for (int i = 1; i < calc_pkg::stage_els; i++)
    begin
      stage_n[i] = stage_r[i-1];
      if (i <= calc_pkg::commit_stage)
      begin
        stage_n[i].poison = stage_r[i-1].poison | flush_i;
      end
    end
  end

  // Fixed latencies, so at most one pipe finishes into any slot
  always_comb
  begin
    comp_n[0] = '0;
    for (int i = 1; i < calc_pkg::stage_els; i++)
    begin
      if ((i-1 == calc_pkg::int_done_stage) && stage_r[i-1].pipe_int_v)
      begin
        comp_n[i] = int_data_i;
      end
      else if ((i-1 == calc_pkg::mul_done_stage) && stage_r[i-1].pipe_mul_v)
      begin
        comp_n[i] = mul_data_i;
      end
      else
      begin
        comp_n[i] = comp_r[i-1];
      end
    end
  end

  // Taps use next-state poison so a flushed result is never bypassed
  always_comb
  begin
    for (int i = 1; i < calc_pkg::stage_els; i++)
    begin
      fwd_v_o[i]    = stage_r[i-1].valid & stage_r[i-1].irf_w_v & ~stage_n[i].poison;
      fwd_rd_o[i]   = stage_r[i-1].rd;
      fwd_data_o[i] = comp_n[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
    comp_r  <= comp_n;
    if (rst_i)
    begin
      for (int i = 0; i < calc_pkg::stage_els; i++)
      begin
        stage_r[i].valid  <= 1'b0;
        stage_r[i].poison <= 1'b0;
      end
    end
  end

  assign commit_v_o  = stage_r[calc_pkg::commit_stage].valid
                     & ~stage_r[calc_pkg::commit_stage].poison;
  assign commit_pc_o = stage_r[calc_pkg::commit_stage].pc;

  assign wb_v_o    = stage_r[calc_pkg::wb_stage].valid
                   & ~stage_r[calc_pkg::wb_stage].poison
                   & stage_r[calc_pkg::wb_stage].irf_w_v;
  assign wb_rd_o   = stage_r[calc_pkg::wb_stage].rd;
  assign wb_data_o = comp_r[calc_pkg::wb_stage];

endmodule

/* design/pipe_mul.sv */
// --------------------
// pipe_mul
// Two-cycle unsigned multiplier, product registered after ex1
// --------------------
`timescale 1ns/1ps

module pipe_mul
  (input  logic               clk_i
   , input  logic               rst_i
   , input  calc_pkg::calc_op_e op_i
   , input  calc_pkg::word_t    rs1_i
   , input  calc_pkg::word_t    rs2_i
   , output calc_pkg::word_t    data_o
   );

  localparam int prod_width = 2 * calc_pkg::word_width;

  logic [prod_width-1:0] prod_r;
  calc_pkg::calc_op_e    op_r;

  // Op follows the product so the half select lines up
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      op_r <= calc_pkg::op_nop;
    end
    else
    begin
      op_r <= op_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    prod_r <= {{calc_pkg::word_width{1'b0}}, rs1_i} * {{calc_pkg::word_width{1'b0}}, rs2_i};
  end

  always_comb
  begin
    case (op_r)
      calc_pkg::op_mul:   data_o = prod_r[calc_pkg::word_width-1:0];
      calc_pkg::op_mulhu: data_o = prod_r[prod_width-1:calc_pkg::word_width];
      default:            data_o = '0;
    endcase
  end

endmodule

/* design/pipe_int.sv */
// --------------------
// pipe_int
// Single-cycle integer ALU working on the ex1 operands
// --------------------
`timescale 1ns/1ps

module pipe_int
  (input  calc_pkg::calc_op_e op_i
   , input  calc_pkg::word_t    rs1_i
   , input  calc_pkg::word_t    rs2_i
   , input  calc_pkg::word_t    imm_i
   , output calc_pkg::word_t    data_o
   );

  logic [4:0] shamt;

  // Only the low bits of rs2 shift
  assign shamt = rs2_i[4:0];

  always_comb
  begin
    case (op_i)
      calc_pkg::op_add:  data_o = rs1_i + rs2_i;
      calc_pkg::op_sub:  data_o = rs1_i - rs2_i;
      calc_pkg::op_and:  data_o = rs1_i & rs2_i;
      calc_pkg::op_or:   data_o = rs1_i | rs2_i;
      calc_pkg::op_xor:  data_o = rs1_i ^ rs2_i;
      calc_pkg::op_sll:  data_o = rs1_i << shamt;
      calc_pkg::op_srl:  data_o = rs1_i >> shamt;
      calc_pkg::op_sra:  data_o = $signed(rs1_i) >>> shamt;
      calc_pkg::op_slt:
      begin
        data_o = ($signed(rs1_i) < $signed(rs2_i)) ? 32'd1 : 32'd0;
      end
      calc_pkg::op_sltu:
      begin
        data_o = (rs1_i < rs2_i) ? 32'd1 : 32'd0;
      end
      calc_pkg::op_addi: data_o = rs1_i + imm_i;
      // Immediate passes straight through
      calc_pkg::op_lui:  data_o = imm_i;
      default:           data_o = '0;
    endcase
  end

endmodule

/* design/calc_issue.sv */
// --------------------
// calc_issue
// Decodes the dispatched op, bypasses operands from results in flight
// and holds the ex1 reservation register
// --------------------
`timescale 1ns/1ps

module calc_issue
  (input  logic                                                   clk_i
   , input  logic                                                   rst_i
   , input  logic                                                   dispatch_v_i
   , input  logic                                                   flush_i
   , input  calc_pkg::calc_op_e                                     dispatch_op_i
   , input  calc_pkg::word_t                                        dispatch_pc_i
   , input  calc_pkg::word_t                                        dispatch_imm_i
   , input  calc_pkg::reg_addr_t                                    dispatch_rd_i
   , input  calc_pkg::reg_addr_t                                    dispatch_rs1_i
   , input  calc_pkg::reg_addr_t                                    dispatch_rs2_i
   , input  calc_pkg::word_t                                        rf_rs1_i
   , input  calc_pkg::word_t                                        rf_rs2_i
   , input  logic [calc_pkg::stage_els-1:1]                         fwd_v_i
   , input  calc_pkg::reg_addr_t [calc_pkg::stage_els-1:1]          fwd_rd_i
   , input  calc_pkg::word_t [calc_pkg::stage_els-1:1]              fwd_data_i
   , output calc_pkg::calc_op_e                                     ex1_op_o
   , output calc_pkg::word_t                                        ex1_rs1_o
   , output calc_pkg::word_t                                        ex1_rs2_o
   , output calc_pkg::word_t                                        ex1_imm_o
   , output calc_pkg::stage_ctl_t                                   isd_ctl_o
   );

  logic            is_int;
  logic            is_mul;
  logic            keep_v;
  calc_pkg::word_t byp_rs1;
  calc_pkg::word_t byp_rs2;

  // Youngest matching entry wins, entry 1 is the youngest
  function automatic calc_pkg::word_t bypass_sel
    (input calc_pkg::reg_addr_t                           addr
     , input calc_pkg::word_t                               rf_data
     , input logic [calc_pkg::stage_els-1:1]                v
     , input calc_pkg::reg_addr_t [calc_pkg::stage_els-1:1] rd
     , input calc_pkg::word_t [calc_pkg::stage_els-1:1]     data
     );
    calc_pkg::word_t sel;
    sel = rf_data;
    for (int i = calc_pkg::stage_els-1; i >= 1; i--)
    begin
      if (v[i] && (rd[i] == addr) && (addr != '0))
      begin
        sel = data[i];
      end
    end
    return sel;
  endfunction

  always_comb
  begin
    is_int = 1'b0;
    is_mul = 1'b0;
    case (dispatch_op_i)
      calc_pkg::op_mul, calc_pkg::op_mulhu: is_mul = 1'b1;
      calc_pkg::op_nop:                     is_int = 1'b0;
      default:                              is_int = 1'b1;
    endcase
  end

  // Flushed or empty slots go down the pipe as a nop
  assign keep_v = dispatch_v_i & ~flush_i;

  assign byp_rs1 = bypass_sel(dispatch_rs1_i, rf_rs1_i, fwd_v_i, fwd_rd_i, fwd_data_i);
  assign byp_rs2 = bypass_sel(dispatch_rs2_i, rf_rs2_i, fwd_v_i, fwd_rd_i, fwd_data_i);

  always_comb
  begin
    isd_ctl_o.valid      = dispatch_v_i;
    isd_ctl_o.poison     = flush_i;
    isd_ctl_o.pipe_int_v = keep_v & is_int;
    isd_ctl_o.pipe_mul_v = keep_v & is_mul;
    isd_ctl_o.irf_w_v    = keep_v & (is_int | is_mul) & (dispatch_rd_i != '0);
    isd_ctl_o.rd         = dispatch_rd_i;
    isd_ctl_o.pc         = dispatch_pc_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ex1_op_o <= calc_pkg::op_nop;
    end
    else
    begin
      ex1_op_o <= keep_v ? dispatch_op_i : calc_pkg::op_nop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ex1_rs1_o <= byp_rs1;
    ex1_rs2_o <= byp_rs2;
    ex1_imm_o <= dispatch_imm_i;
  end

endmodule

/* design/int_regfile.sv */
// --------------------
// int_regfile
// Integer register file, two read ports with write-through,
// one write port, register zero hard-wired
// --------------------
`timescale 1ns/1ps

module int_regfile
  (input  logic                clk_i
   , input  logic                rst_i
   , input  calc_pkg::reg_addr_t rs1_addr_i
   , input  calc_pkg::reg_addr_t rs2_addr_i
   , output calc_pkg::word_t     rs1_data_o
   , output calc_pkg::word_t     rs2_data_o
   , input  logic                w_v_i
   , input  calc_pkg::reg_addr_t w_addr_i
   , input  calc_pkg::word_t     w_data_i
   );

  calc_pkg::word_t [calc_pkg::num_regs-1:0] regs_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      regs_r <= '0;
    end
    else if (w_v_i && (w_addr_i != '0))
    begin
      regs_r[w_addr_i] <= w_data_i;
    end
  end

  // Same-cycle write wins over the stored value
  assign rs1_data_o = (rs1_addr_i == '0) ? '0
                    : (w_v_i && (w_addr_i == rs1_addr_i)) ? w_data_i : regs_r[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0
                    : (w_v_i && (w_addr_i == rs2_addr_i)) ? w_data_i : regs_r[rs2_addr_i];

endmodule

/* design/calc_pkg.sv */
// --------------------
// calc_pkg
// Shared widths, stage indices, opcode encoding and the per-stage
// control record of the integer calculator back end
// --------------------

package calc_pkg;

  // Data and register file geometry
  localparam int word_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;

  typedef logic [word_width-1:0]     word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  // Tracked stages ex1, ex2, ex3, wb
  localparam int stage_els = 4;

  // Stage whose entry muxes that pipe's result into the next completion slot
  localparam int int_done_stage = 0;
  localparam int mul_done_stage = 1;

  localparam int commit_stage = 2;
  localparam int wb_stage     = 3;

  typedef enum logic [3:0]
  {
    op_add
    , op_sub
    , op_and
    , op_or
    , op_xor
    , op_sll
    , op_srl
    , op_sra
    , op_slt
    , op_sltu
    , op_addi
    , op_lui
    , op_mul
    , op_mulhu
    , op_nop
  } calc_op_e;

  typedef struct packed
  {
    logic      valid;
    logic      poison;
    logic      pipe_int_v;
    logic      pipe_mul_v;
    logic      irf_w_v;
    reg_addr_t rd;
    word_t     pc;
  } stage_ctl_t;

endpackage
